//--- src/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT; // One bus or register word

    // Instruction field positions
    localparam int opHi = 31;
    localparam int opLo = 27;
    localparam int raHi = 26;
    localparam int raLo = 23;
    localparam int rbHi = 22;
    localparam int rbLo = 19;
    localparam int rcHi = 18;
    localparam int rcLo = 15;
    localparam int constHi = 18;
    localparam int constLo = 0;

    typedef enum logic [4:0] {
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14,
        opIn   = 5'd22,
        opOut  = 5'd23,
        opHalt = 5'd27
    } opcodeT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOpT;

    typedef enum logic [1:0] {stIdle, stRun, stHalted} seqStateT;

    typedef logic [2:0] stepT;

    localparam stepT stepShortLast = 3'd3; // Last step of in, out and halt
    localparam stepT stepLast = 3'd5;      // Last step of ALU ops, counter ceiling

endpackage

//--- src/stepCounter.sv
`timescale 1ns/1ns
module stepCounter (
    input  logic              clk,
    input  logic              arstN,
    input  logic              stepClear,
    input  logic              stepEnable,
    output cpuPkg::stepT      step
);

    // T-step of the instruction in flight
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            step <= '0;
        end else if (stepClear) begin
            step <= '0; // Clear wins over enable
        end else if (stepEnable && step != cpuPkg::stepLast) begin
            step <= step + 3'd1;
        end
    end

endmodule

//--- src/controlSequencer.sv
`timescale 1ns/1ns
module controlSequencer (
    input  logic              clk,
    input  logic              arstN,
    input  logic              start,
    input  cpuPkg::opcodeT    opcode,
    input  cpuPkg::stepT      step,
    output logic              stepClear,
    output logic              stepEnable,
    output logic              pcOut,
    output logic              zLowOut,
    output logic              mdrOut,
    output logic              rOut,
    output logic              cOut,
    output logic              inPortOut,
    output logic              pcIn,
    output logic              irIn,
    output logic              yIn,
    output logic              zIn,
    output logic              marIn,
    output logic              mdrIn,
    output logic              rIn,
    output logic              outPortIn,
    output logic              incPc,
    output logic              read,
    output logic              gra,
    output logic              grb,
    output logic              grc,
    output cpuPkg::aluOpT     aluOp,
    output logic              busy,
    output logic              halted
);

    cpuPkg::seqStateT state;
    cpuPkg::aluOpT    aluSel;
    logic             isRr;
    logic             isImm;
    logic             isIn;
    logic             isOut;
    logic             isAlu;
    logic             isHalt;
    logic             running;
    logic             lastStep;

    // Opcode classes and ALU mapping
    always_comb begin
        isRr = 1'b0;
        isImm = 1'b0;
        isIn = 1'b0;
        isOut = 1'b0;
        aluSel = cpuPkg::aluAdd;
        case (opcode)
            cpuPkg::opAdd:  isRr = 1'b1;
            cpuPkg::opSub: begin
                isRr = 1'b1;
                aluSel = cpuPkg::aluSub;
            end
            cpuPkg::opAnd: begin
                isRr = 1'b1;
                aluSel = cpuPkg::aluAnd;
            end
            cpuPkg::opOr: begin
                isRr = 1'b1;
                aluSel = cpuPkg::aluOr;
            end
            cpuPkg::opAddi: isImm = 1'b1;
            cpuPkg::opAndi: begin
                isImm = 1'b1;
                aluSel = cpuPkg::aluAnd;
            end
            cpuPkg::opOri: begin
                isImm = 1'b1;
                aluSel = cpuPkg::aluOr;
            end
            cpuPkg::opIn:   isIn = 1'b1;
            cpuPkg::opOut:  isOut = 1'b1;
            default: ; // opHalt and unknown codes
        endcase
    end

    assign isAlu = isRr | isImm;
    assign isHalt = !(isAlu || isIn || isOut);
    assign running = (state == cpuPkg::stRun);
    assign lastStep = isAlu ? (step == cpuPkg::stepLast) : (step == cpuPkg::stepShortLast);

    assign stepClear = (start && !running) || (running && lastStep);
    assign stepEnable = running;
    assign busy = running;
    assign halted = (state == cpuPkg::stHalted);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::stIdle;
        end else begin
            case (state)
                cpuPkg::stIdle, cpuPkg::stHalted: begin
                    if (start) state <= cpuPkg::stRun;
                end
                cpuPkg::stRun: begin
                    if (isHalt && step == cpuPkg::stepShortLast) state <= cpuPkg::stHalted;
                end
                default: state <= cpuPkg::stIdle;
            endcase
        end
    end

    // Strobe decode, all quiet outside stRun
    always_comb begin
        pcOut = 1'b0;
        zLowOut = 1'b0;
        mdrOut = 1'b0;
        rOut = 1'b0;
        cOut = 1'b0;
        inPortOut = 1'b0;
        pcIn = 1'b0;
        irIn = 1'b0;
        yIn = 1'b0;
        zIn = 1'b0;
        marIn = 1'b0;
        mdrIn = 1'b0;
        rIn = 1'b0;
        outPortIn = 1'b0;
        incPc = 1'b0;
        read = 1'b0;
        gra = 1'b0;
        grb = 1'b0;
        grc = 1'b0;
        aluOp = cpuPkg::aluAdd;
        if (running) begin
            case (step)
                3'd0: begin // PC to MAR, Z gets PC + 1
                    pcOut = 1'b1;
                    marIn = 1'b1;
                    incPc = 1'b1;
                    zIn = 1'b1;
                end
                3'd1: begin
                    zLowOut = 1'b1;
                    pcIn = 1'b1;
                    read = 1'b1;
                    mdrIn = 1'b1;
                end
                3'd2: begin
                    mdrOut = 1'b1;
                    irIn = 1'b1;
                end
                3'd3: begin
                    if (isAlu) begin // Y gets R[rb]
                        grb = 1'b1;
                        rOut = 1'b1;
                        yIn = 1'b1;
                    end else if (isIn) begin
                        inPortOut = 1'b1;
                        gra = 1'b1;
                        rIn = 1'b1;
                    end else if (isOut) begin
                        gra = 1'b1;
                        rOut = 1'b1;
                        outPortIn = 1'b1;
                    end
                end
                3'd4: begin
                    if (isAlu) begin
                        zIn = 1'b1;
                        aluOp = aluSel;
                        if (isImm) begin
                            cOut = 1'b1; // Sign-extended constant as operand
                        end else begin
                            grc = 1'b1;
                            rOut = 1'b1;
                        end
                    end
                end
                3'd5: begin
                    if (isAlu) begin // Result back to R[ra]
                        zLowOut = 1'b1;
                        gra = 1'b1;
                        rIn = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ns
module registerFile (
    input  logic              clk,
    input  logic              arstN,
    input  cpuPkg::wordT      ir,
    input  logic              gra,
    input  logic              grb,
    input  logic              grc,
    input  logic              rIn,
    input  cpuPkg::wordT      busIn,
    output cpuPkg::wordT      regOut
);

    cpuPkg::wordT regs [16];
    logic [3:0]   sel;

    // Select and encode, ra over rb over rc
    always_comb begin
        if (gra) begin
            sel = ir[cpuPkg::raHi:cpuPkg::raLo];
        end else if (grb) begin
            sel = ir[cpuPkg::rbHi:cpuPkg::rbLo];
        end else if (grc) begin
            sel = ir[cpuPkg::rcHi:cpuPkg::rcLo];
        end else begin
            sel = 4'd0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= busIn;
        end
    end

    assign regOut = regs[sel]; // Only driven onto the bus with rOut

endmodule

//--- src/alu.sv
`timescale 1ns/1ns
module alu (
    input  cpuPkg::wordT      a,
    input  cpuPkg::wordT      b,
    input  cpuPkg::aluOpT     aluOp,
    input  logic              incPc,
    output cpuPkg::wordT      result
);

    // a comes from Y, b from the bus
    always_comb begin
        if (incPc) begin
            result = b + 32'd1; // PC increment during fetch
        end else begin
            case (aluOp)
                cpuPkg::aluAdd: result = a + b;
                cpuPkg::aluSub: result = a - b;
                cpuPkg::aluAnd: result = a & b;
                cpuPkg::aluOr:  result = a | b;
                default:        result = '0;
            endcase
        end
    end

endmodule

//--- src/programMemory.sv
`timescale 1ns/1ns
module programMemory #(
    parameter int memAddrWidth = 6
) (
    input  logic                    clk,
    input  logic                    loadEn,
    input  logic [memAddrWidth-1:0] loadAddr,
    input  cpuPkg::wordT            loadData,
    input  logic [memAddrWidth-1:0] addr,
    output cpuPkg::wordT            memData
);

    cpuPkg::wordT mem [2**memAddrWidth];

    // Loader port, one word per cycle
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign memData = mem[addr]; // Read without a clock

endmodule

//--- src/busDatapath.sv
`timescale 1ns/1ns
module busDatapath #(
    parameter int memAddrWidth = 6
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    pcOut,
    input  logic                    zLowOut,
    input  logic                    mdrOut,
    input  logic                    rOut,
    input  logic                    cOut,
    input  logic                    inPortOut,
    input  logic                    pcIn,
    input  logic                    irIn,
    input  logic                    yIn,
    input  logic                    zIn,
    input  logic                    marIn,
    input  logic                    mdrIn,
    input  logic                    rIn,
    input  logic                    outPortIn,
    input  logic                    incPc,
    input  logic                    read,
    input  logic                    gra,
    input  logic                    grb,
    input  logic                    grc,
    input  cpuPkg::aluOpT           aluOp,
    input  logic                    start,
    input  cpuPkg::wordT            memData,
    input  cpuPkg::wordT            inPortData,
    output cpuPkg::opcodeT          opcode,
    output logic [memAddrWidth-1:0] mar,
    output cpuPkg::wordT            outPortData
);

    cpuPkg::wordT bus;
    cpuPkg::wordT pc;
    cpuPkg::wordT ir;
    cpuPkg::wordT mdr;
    cpuPkg::wordT y;
    cpuPkg::wordT z;
    cpuPkg::wordT regOut;
    cpuPkg::wordT aluResult;
    cpuPkg::wordT cExt;

    assign cExt = {{13{ir[cpuPkg::constHi]}}, ir[cpuPkg::constHi:cpuPkg::constLo]};
    assign opcode = cpuPkg::opcodeT'(ir[cpuPkg::opHi:cpuPkg::opLo]);

    // Bus driver select
    always_comb begin
        if (pcOut) begin
            bus = pc;
        end else if (zLowOut) begin
            bus = z;
        end else if (mdrOut) begin
            bus = mdr;
        end else if (rOut) begin
            bus = regOut;
        end else if (cOut) begin
            bus = cExt;
        end else if (inPortOut) begin
            bus = inPortData;
        end else begin
            bus = '0; // Idle bus
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            outPortData <= '0;
        end else begin
            if (start) begin
                pc <= '0; // Program always starts at word 0
            end else if (pcIn) begin
                pc <= bus;
            end
            if (outPortIn) outPortData <= bus; // Holds until the next out
        end
    end

    always_ff @(posedge clk) begin
        if (irIn) ir <= bus;
        if (marIn) mar <= bus[memAddrWidth-1:0];
        if (mdrIn) mdr <= read ? memData : bus;
        if (yIn) y <= bus;
        if (zIn) z <= aluResult;
    end

    registerFile regFile0 (
        .clk    (clk),
        .arstN  (arstN),
        .ir     (ir),
        .gra    (gra),
        .grb    (grb),
        .grc    (grc),
        .rIn    (rIn),
        .busIn  (bus),
        .regOut (regOut)
    );

    alu alu0 (
        .a      (y),
        .b      (bus),
        .aluOp  (aluOp),
        .incPc  (incPc),
        .result (aluResult)
    );

endmodule

//--- src/cpuTop.sv
`timescale 1ns/1ns
module cpuTop #(
    parameter int memAddrWidth = 6
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    start,
    input  logic                    loadEn,
    input  logic [memAddrWidth-1:0] loadAddr,
    input  cpuPkg::wordT            loadData,
    input  cpuPkg::wordT            inPortData,
    output cpuPkg::wordT            outPortData,
    output logic                    busy,
    output logic                    halted
);

    logic pcOut, zLowOut, mdrOut, rOut, cOut, inPortOut;
    logic pcIn, irIn, yIn, zIn, marIn, mdrIn, rIn, outPortIn;
    logic incPc, read, gra, grb, grc;
    logic stepClear, stepEnable;
    cpuPkg::aluOpT           aluOp;
    cpuPkg::opcodeT          opcode;
    cpuPkg::stepT            step;
    cpuPkg::wordT            memData;
    logic [memAddrWidth-1:0] mar;

    controlSequencer seq0 (
        .clk (clk), .arstN (arstN), .start (start), .opcode (opcode), .step (step),
        .stepClear (stepClear), .stepEnable (stepEnable),
        .pcOut (pcOut), .zLowOut (zLowOut), .mdrOut (mdrOut), .rOut (rOut), .cOut (cOut),
        .inPortOut (inPortOut), .pcIn (pcIn), .irIn (irIn), .yIn (yIn), .zIn (zIn),
        .marIn (marIn), .mdrIn (mdrIn), .rIn (rIn), .outPortIn (outPortIn),
        .incPc (incPc), .read (read), .gra (gra), .grb (grb), .grc (grc),
        .aluOp (aluOp), .busy (busy), .halted (halted)
    );

    stepCounter stepCnt0 (
        .clk (clk), .arstN (arstN), .stepClear (stepClear), .stepEnable (stepEnable),
        .step (step)
    );

    busDatapath #(.memAddrWidth(memAddrWidth)) datapath0 (
        .clk (clk), .arstN (arstN),
        .pcOut (pcOut), .zLowOut (zLowOut), .mdrOut (mdrOut), .rOut (rOut), .cOut (cOut),
        .inPortOut (inPortOut), .pcIn (pcIn), .irIn (irIn), .yIn (yIn), .zIn (zIn),
        .marIn (marIn), .mdrIn (mdrIn), .rIn (rIn), .outPortIn (outPortIn),
        .incPc (incPc), .read (read), .gra (gra), .grb (grb), .grc (grc),
        .aluOp (aluOp), .start (start), .memData (memData), .inPortData (inPortData),
        .opcode (opcode), .mar (mar), .outPortData (outPortData)
    );

    programMemory #(.memAddrWidth(memAddrWidth)) progMem0 (
        .clk (clk), .loadEn (loadEn), .loadAddr (loadAddr), .loadData (loadData),
        .addr (mar), .memData (memData)
    );

endmodule

//--- testbench/cpuTop_assertions.sv
`timescale 1ns/1ns
module cpuTopAssertions (
    input logic          clk,
    input logic          arstN,
    input logic          busy,
    input cpuPkg::stepT  step,
    input cpuPkg::aluOpT aluOp,
    input logic          pcOut,
    input logic          zLowOut,
    input logic          mdrOut,
    input logic          rOut,
    input logic          cOut,
    input logic          inPortOut,
    input logic          pcIn,
    input logic          irIn,
    input logic          yIn,
    input logic          zIn,
    input logic          marIn,
    input logic          mdrIn,
    input logic          rIn,
    input logic          outPortIn,
    input logic          incPc,
    input logic          read,
    input logic          gra,
    input logic          grb,
    input logic          grc
);

    logic [5:0] drivers;
    logic       anyStrobe;

    assign drivers = {pcOut, zLowOut, mdrOut, rOut, cOut, inPortOut};
    assign anyStrobe = (|drivers) | pcIn | irIn | yIn | zIn | marIn | mdrIn | rIn
                     | outPortIn | incPc | read | gra | grb | grc
                     | (aluOp != cpuPkg::aluAdd);

    oneDriver: assert property (@(posedge clk) disable iff (!arstN) $onehot0(drivers))
        else $error("More than one bus driver active");

    // Strobes only while an instruction runs
    quietIdle: assert property (@(posedge clk) disable iff (!arstN) !busy |-> !anyStrobe)
        else $error("Strobe active outside the run state");

    stepRange: assert property (@(posedge clk) disable iff (!arstN) step <= 3'd5)
        else $error("Step counter beyond T5");

endmodule

//--- testbench/cpuTb.sv
`timescale 1ns/1ns
module cpuTb;

    localparam int memAddrWidth = 6;
    localparam int rows = 8;
    localparam int progLen = 5;
    localparam int outCycle = 4 + 6 + 6 + 4;   // in, imm op, rr op, out
    localparam int progCycles = outCycle + 4;  // Plus halt
    localparam int timeoutCycles = 10 + rows * 40 + 50;

    logic                    clk;
    logic                    arstN;
    logic                    start;
    logic                    loadEn;
    logic [memAddrWidth-1:0] loadAddr;
    cpuPkg::wordT            loadData;
    cpuPkg::wordT            inPortData;
    cpuPkg::wordT            outPortData;
    logic                    busy;
    logic                    halted;

    // Stimulus table with one program per row
    cpuPkg::opcodeT rrTab [rows];
    cpuPkg::opcodeT immTab [rows];
    logic [18:0]    constTab [rows];
    cpuPkg::wordT   inTab [rows];
    logic           randTab [rows];   // Constant and input come from the LFSR

    logic [31:0] lfsrState = 32'd97386;
    int          cycleCount = 0;

    cpuTop #(.memAddrWidth(memAddrWidth)) dut0 (
        .clk (clk), .arstN (arstN), .start (start), .loadEn (loadEn),
        .loadAddr (loadAddr), .loadData (loadData), .inPortData (inPortData),
        .outPortData (outPortData), .busy (busy), .halted (halted)
    );

    bind controlSequencer cpuTopAssertions asrt0 (
        .clk (clk), .arstN (arstN), .busy (busy), .step (step), .aluOp (aluOp),
        .pcOut (pcOut), .zLowOut (zLowOut), .mdrOut (mdrOut), .rOut (rOut),
        .cOut (cOut), .inPortOut (inPortOut), .pcIn (pcIn), .irIn (irIn),
        .yIn (yIn), .zIn (zIn), .marIn (marIn), .mdrIn (mdrIn), .rIn (rIn),
        .outPortIn (outPortIn), .incPc (incPc), .read (read),
        .gra (gra), .grb (grb), .grc (grc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            endRunFailed();
        end
    end

    task automatic endRunFailed();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on an error");
    endtask

    task automatic checkWord(input string name, input cpuPkg::wordT expected,
                             input cpuPkg::wordT actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            endRunFailed();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
            endRunFailed();
        end
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    task automatic drawBits(input int nBits, output cpuPkg::wordT value);
        value = '0;
        repeat (nBits) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    function automatic cpuPkg::wordT mkInstr(input cpuPkg::opcodeT op, input logic [3:0] ra,
                                             input logic [3:0] rb, input logic [18:0] low);
        return {op, ra, rb, low};
    endfunction

    // Expected R3 of one table row
    function automatic cpuPkg::wordT modelResult(input cpuPkg::opcodeT rrOp,
                                                 input cpuPkg::opcodeT immOp,
                                                 input logic [18:0] c,
                                                 input cpuPkg::wordT inVal);
        cpuPkg::wordT cExt;
        cpuPkg::wordT r2;
        cpuPkg::wordT r3;
        cExt = 32'($signed(c));
        case (immOp)
            cpuPkg::opAndi: r2 = inVal & cExt;
            cpuPkg::opOri:  r2 = inVal | cExt;
            default:        r2 = inVal + cExt;
        endcase
        case (rrOp)
            cpuPkg::opSub: r3 = inVal - r2;
            cpuPkg::opAnd: r3 = inVal & r2;
            cpuPkg::opOr:  r3 = inVal | r2;
            default:       r3 = inVal + r2;
        endcase
        return r3;
    endfunction

    task automatic loadWord(input int addr, input cpuPkg::wordT word);
        @(posedge clk);
        #2;
        loadEn = 1'b1;
        loadAddr = memAddrWidth'(addr);
        loadData = word;
    endtask

    initial begin
        cpuPkg::wordT prog [progLen];
        cpuPkg::wordT expOut;
        cpuPkg::wordT prevOut;
        cpuPkg::wordT inVal;
        cpuPkg::wordT draw;
        logic [18:0]  c;
        int           busyCount;
        arstN = 1'b0;
        start = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        inPortData = '0;
        rrTab = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                  cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opAdd, cpuPkg::opOr};
        immTab = '{cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opAddi,
                   cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opAndi};
        constTab = '{19'h7FFFD, 19'h0F0F0, 19'h40001, 19'h00100,
                     19'h0, 19'h0, 19'h0, 19'h7FFFF};
        inTab = '{32'h0000_0010, 32'h1234_5678, 32'hA5A5_0F0F, 32'hFFFF_FFF0,
                  32'h0, 32'h0, 32'h0, 32'h8001_7FFE};
        randTab = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
        repeat (10) @(posedge clk);
        #2;
        arstN = 1'b1;
        @(negedge clk);
        checkFlag("busy", 1'b0, busy);
        checkFlag("halted", 1'b0, halted);
        checkWord("outPortData", '0, outPortData);
        prevOut = '0;
        for (int r = 0; r < rows; r++) begin
            c = constTab[r];
            inVal = inTab[r];
            if (randTab[r]) begin
                drawBits(19, draw);
                c = draw[18:0];
                drawBits(32, inVal);
            end
            expOut = modelResult(rrTab[r], immTab[r], c, inVal);
            prog[0] = mkInstr(cpuPkg::opIn, 4'd1, 4'd0, 19'd0);
            prog[1] = mkInstr(immTab[r], 4'd2, 4'd1, c);
            prog[2] = mkInstr(rrTab[r], 4'd3, 4'd1, {4'd2, 15'd0});
            prog[3] = mkInstr(cpuPkg::opOut, 4'd3, 4'd0, 19'd0);
            prog[4] = mkInstr(cpuPkg::opHalt, 4'd0, 4'd0, 19'd0);
            for (int i = 0; i < progLen; i++) begin
                loadWord(i, prog[i]);
            end
            @(posedge clk);
            #2;
            loadEn = 1'b0;
            inPortData = inVal;
            start = 1'b1;
            @(posedge clk);
            #2;
            start = 1'b0;
            busyCount = 0;
            @(negedge clk);
            while (!halted) begin
                checkFlag("busy", 1'b1, busy);
                // Old value until the out step has stored the new one
                checkWord("outPortData", (busyCount < outCycle) ? prevOut : expOut,
                          outPortData);
                busyCount++;
                @(negedge clk);
            end
            checkFlag("busy", 1'b0, busy);
            checkWord("busy cycles", cpuPkg::wordT'(progCycles), cpuPkg::wordT'(busyCount));
            repeat (2) begin // Idle gap after halt
                @(negedge clk);
                checkFlag("halted", 1'b1, halted);
                checkWord("outPortData", expOut, outPortData);
            end
            prevOut = expOut;
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- all.f
src/cpuPkg.sv
src/stepCounter.sv
src/controlSequencer.sv
src/registerFile.sv
src/alu.sv
src/programMemory.sv
src/busDatapath.sv
src/cpuTop.sv
testbench/cpuTop_assertions.sv
testbench/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
failText="Simulation finished: FAIL"

verilator --binary --timing --assert --top-module cpuTb \
    -Mdir "$buildDir" -o cpuSim -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/cpuSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

# The log decides, a crash without the message also fails
if grep -q "$failText" "$logFile"; then
    echo "Failing run, see $logFile"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi
echo "Passing run"
exit 0
